//--- logic/alu.sv
module alu (
   input  rv_pkg::alu_op_t op_i,
   input  rv_pkg::word_t   a_i,
   input  rv_pkg::word_t   b_i,
   output rv_pkg::word_t   y_o
);
   import rv_pkg::*;

   logic lt_signed;

   assign lt_signed = $signed(a_i) < $signed(b_i);

   always_comb begin
      case (op_i)
         ALU_ADD: y_o = a_i + b_i;
         ALU_SUB: y_o = a_i - b_i;
         ALU_AND: y_o = a_i & b_i;
         ALU_OR:  y_o = a_i | b_i;
         ALU_XOR: y_o = a_i ^ b_i;
         ALU_SLT: y_o = {31'b0, lt_signed};
         // Compare results feed the branch decision through bit 0
         ALU_EQ:  y_o = {31'b0, a_i == b_i};
         ALU_NE:  y_o = {31'b0, a_i != b_i};
         default: y_o = '0;
      endcase
   end

endmodule

//--- logic/csr_timer.sv
module csr_timer (
   input  logic              clk,
   input  logic              rst,
   input  logic              csr_we_i,
   input  rv_pkg::csr_addr_t csr_addr_i,
   input  rv_pkg::word_t     csr_wd_i,
   output rv_pkg::word_t     csr_rd_o,
   input  logic              tmr_we_i,
   input  rv_pkg::word_t     tmr_addr_i,
   input  rv_pkg::word_t     tmr_wd_i,
   output rv_pkg::word_t     tmr_rd_o,
   input  rv_pkg::trap_t     trap_i,
   input  logic              mret_i,
   input  rv_pkg::word_t     pc_i,
   output rv_pkg::word_t     mtvec_o,
   output rv_pkg::word_t     mepc_o,
   output logic              timer_pend_o
);
   import rv_pkg::*;

   word_t mtvec_q;
   word_t mepc_q;
   word_t mcause_q;
   word_t mie_q;
   word_t mtime_q;
   word_t mtimecmp_q;
   // Saved timer enable, brought back by mret
   logic  mpie_q;

   ////////////////////////////////////////
   // CSR read and write
   ////////////////////////////////////////

   always_comb begin
      case (csr_addr_i)
         CSR_MTVEC:  csr_rd_o = mtvec_q;
         CSR_MEPC:   csr_rd_o = mepc_q;
         CSR_MCAUSE: csr_rd_o = mcause_q;
         CSR_MIE:    csr_rd_o = mie_q;
         default:    csr_rd_o = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mie_q <= '0;
         mpie_q <= 1'b0;
      end else if (trap_i.take) begin
         mpie_q <= mie_q[7];
         mie_q[7] <= 1'b0;
      end else if (mret_i) begin
         mie_q[7] <= mpie_q;
      end else if (csr_we_i && (csr_addr_i == CSR_MIE)) begin
         mie_q <= csr_wd_i;
      end
   end

   always_ff @(posedge clk) begin
      if (trap_i.take) begin
         mepc_q <= pc_i;
         mcause_q <= trap_i.cause;
      end else if (csr_we_i) begin
         case (csr_addr_i)
            CSR_MTVEC:  mtvec_q <= csr_wd_i;
            CSR_MEPC:   mepc_q <= csr_wd_i;
            CSR_MCAUSE: mcause_q <= csr_wd_i;
            default:    ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Timer
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         mtime_q <= '0;
         mtimecmp_q <= '1;
      end else begin
         mtime_q <= mtime_q + 32'd1;
         // A store to mtime wins over the increment
         if (tmr_we_i && (tmr_addr_i == MTIME_ADDR)) begin
            mtime_q <= tmr_wd_i;
         end
         if (tmr_we_i && (tmr_addr_i == MTIMECMP_ADDR)) begin
            mtimecmp_q <= tmr_wd_i;
         end
      end
   end

   assign tmr_rd_o = (tmr_addr_i == MTIMECMP_ADDR) ? mtimecmp_q : mtime_q;
   assign timer_pend_o = mie_q[7] && (mtime_q >= mtimecmp_q);
   assign mtvec_o = mtvec_q;
   assign mepc_o = mepc_q;

   // Core must drop the CSR write of a trapping instruction
   a_no_trap_csr_we: assert property (@(posedge clk) disable iff (rst)
      !(trap_i.take && csr_we_i));

endmodule

//--- logic/data_ram.sv
module data_ram #(
   parameter int DEPTH = 64
) (
   input  logic          clk,
   input  logic          we_i,
   input  rv_pkg::word_t addr_i,
   input  rv_pkg::word_t wd_i,
   output rv_pkg::word_t rd_o
);
   import rv_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   word_t          mem [DEPTH];
   word_t          word_idx;
   logic [AW-1:0]  slot;
   logic           in_range;

   // Word index from bit 2 up
   assign word_idx = {2'b00, addr_i[31:2]};
   assign slot = word_idx[AW-1:0];
   assign in_range = word_idx < word_t'(DEPTH);

   always_ff @(posedge clk) begin
      if (we_i && in_range) begin
         mem[slot] <= wd_i;
      end
   end

   assign rd_o = in_range ? mem[slot] : '0;

endmodule

//--- logic/reg_file.sv
module reg_file (
   input  logic             clk,
   input  logic             rst,
   input  rv_pkg::reg_idx_t rs1_i,
   input  rv_pkg::reg_idx_t rs2_i,
   input  rv_pkg::reg_idx_t rd_i,
   input  logic             we_i,
   input  rv_pkg::word_t    wd_i,
   output rv_pkg::word_t    rd1_o,
   output rv_pkg::word_t    rd2_o
);
   import rv_pkg::*;

   // x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (rd_i != '0)) begin
         regs[rd_i] <= wd_i;
      end
   end

   assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

   a_x0_zero: assert property (@(posedge clk) disable iff (rst)
      (rs1_i == '0) |-> (rd1_o == '0));

endmodule

//--- logic/rv_core.sv
module rv_core (
   input  logic           clk,
   input  logic           rst,
   input  rv_pkg::instr_t instr_i,
   output rv_pkg::word_t  pc_o,
   output rv_pkg::word_t  mem_addr_o,
   output rv_pkg::word_t  mem_wd_o,
   output logic           mem_we_o,
   input  rv_pkg::word_t  mem_rd_i
);
   import rv_pkg::*;

   word_t    pc_q;
   word_t    pc_next;
   word_t    pc_plus4;
   word_t    pc_target;
   pc_src_t  pc_src;
   decoded_t dec;
   ctrl_t    ctrl;
   trap_t    trap;
   word_t    rs1_val;
   word_t    rs2_val;
   word_t    alu_b;
   word_t    alu_y;
   word_t    wb_data;
   word_t    load_data;
   word_t    csr_rd;
   word_t    tmr_rd;
   word_t    mtvec;
   word_t    mepc;
   logic     timer_pend;
   logic     tmr_sel;
   logic     br_taken;

   assign dec = decode(instr_i);
   assign ctrl = dec.ctrl;

   ////////////////////////////////////////
   // Execute
   ////////////////////////////////////////

   reg_file u_reg_file (
      .clk   (clk),
      .rst   (rst),
      .rs1_i (dec.rs1),
      .rs2_i (dec.rs2),
      .rd_i  (dec.rd),
      .we_i  (ctrl.reg_write && !trap.take),
      .wd_i  (wb_data),
      .rd1_o (rs1_val),
      .rd2_o (rs2_val)
   );

   assign alu_b = ctrl.alu_imm ? dec.imm : rs2_val;

   alu u_alu (
      .op_i (ctrl.alu_op),
      .a_i  (rs1_val),
      .b_i  (alu_b),
      .y_o  (alu_y)
   );

   // Timer registers are decoded out of the RAM path
   assign tmr_sel = (alu_y == MTIME_ADDR) || (alu_y == MTIMECMP_ADDR);

   csr_timer u_csr_timer (
      .clk          (clk),
      .rst          (rst),
      .csr_we_i     (ctrl.csr_write && !trap.take),
      .csr_addr_i   (dec.csr),
      .csr_wd_i     (rs1_val),
      .csr_rd_o     (csr_rd),
      .tmr_we_i     (ctrl.mem_write && tmr_sel && !trap.take),
      .tmr_addr_i   (alu_y),
      .tmr_wd_i     (rs2_val),
      .tmr_rd_o     (tmr_rd),
      .trap_i       (trap),
      .mret_i       (ctrl.is_mret && !trap.take),
      .pc_i         (pc_q),
      .mtvec_o      (mtvec),
      .mepc_o       (mepc),
      .timer_pend_o (timer_pend)
   );

   trap_detect u_trap_detect (
      .ctrl_i       (ctrl),
      .addr_i       (alu_y),
      .timer_pend_i (timer_pend),
      .trap_o       (trap)
   );

   ////////////////////////////////////////
   // Memory and write-back
   ////////////////////////////////////////

   // Strobe covers RAM and timer stores, RAM sits below the timer window
   assign mem_addr_o = alu_y;
   assign mem_wd_o = rs2_val;
   assign mem_we_o = ctrl.mem_write && !trap.take;
   assign load_data = tmr_sel ? tmr_rd : mem_rd_i;

   always_comb begin
      case (ctrl.wb_src)
         WB_MEM:  wb_data = load_data;
         WB_PC4:  wb_data = pc_plus4;
         WB_CSR:  wb_data = csr_rd;
         WB_IMM:  wb_data = dec.imm;
         default: wb_data = alu_y;
      endcase
   end

   ////////////////////////////////////////
   // Next PC
   ////////////////////////////////////////

   assign pc_plus4 = pc_q + 32'd4;
   assign pc_target = pc_q + dec.imm;
   assign br_taken = ctrl.is_branch && alu_y[0];

   always_comb begin
      if (trap.take) begin
         pc_src = PC_TRAP;
      end else if (ctrl.is_mret) begin
         pc_src = PC_MRET;
      end else if (ctrl.is_jal) begin
         pc_src = PC_JAL;
      end else if (br_taken) begin
         pc_src = PC_BRANCH;
      end else begin
         pc_src = PC_PLUS4;
      end
   end

   always_comb begin
      case (pc_src)
         PC_TRAP:           pc_next = mtvec;
         PC_MRET:           pc_next = mepc;
         PC_JAL, PC_BRANCH: pc_next = pc_target;
         default:           pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= '0;
      end else begin
         pc_q <= pc_next;
      end
   end

   assign pc_o = pc_q;

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [6:0]  opcode_t;

   // Major opcodes of the supported subset
   localparam opcode_t OP_REG    = 7'b0110011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_SYSTEM = 7'b1110011;

   localparam instr_t INSTR_ECALL = 32'h0000_0073;
   localparam instr_t INSTR_MRET  = 32'h3020_0073;

   localparam csr_addr_t CSR_MIE    = 12'h304;
   localparam csr_addr_t CSR_MTVEC  = 12'h305;
   localparam csr_addr_t CSR_MEPC   = 12'h341;
   localparam csr_addr_t CSR_MCAUSE = 12'h342;

   // Timer window, low 32 bits only
   localparam word_t MTIME_ADDR    = 32'h0000_1000;
   localparam word_t MTIMECMP_ADDR = 32'h0000_1004;

   localparam word_t CAUSE_ILLEGAL     = 32'd2;
   localparam word_t CAUSE_LD_MISALIGN = 32'd4;
   localparam word_t CAUSE_ST_MISALIGN = 32'd6;
   localparam word_t CAUSE_ECALL       = 32'd11;
   localparam word_t CAUSE_TIMER       = 32'h8000_0007;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_EQ, ALU_NE
   } alu_op_t;

   typedef enum logic [2:0] {
      PC_PLUS4, PC_BRANCH, PC_JAL, PC_TRAP, PC_MRET
   } pc_src_t;

   typedef enum logic [2:0] {
      WB_ALU, WB_MEM, WB_PC4, WB_CSR, WB_IMM
   } wb_src_t;

   typedef struct packed {
      alu_op_t alu_op;
      logic    alu_imm;
      logic    reg_write;
      wb_src_t wb_src;
      logic    mem_read;
      logic    mem_write;
      logic    is_branch;
      logic    is_jal;
      logic    csr_write;
      logic    is_ecall;
      logic    is_mret;
      logic    illegal;
   } ctrl_t;

   typedef struct packed {
      reg_idx_t  rs1;
      reg_idx_t  rs2;
      reg_idx_t  rd;
      word_t     imm;
      csr_addr_t csr;
      ctrl_t     ctrl;
   } decoded_t;

   typedef struct packed {
      logic  take;
      word_t cause;
   } trap_t;

   function automatic decoded_t decode(instr_t instr);
      decoded_t   d;
      logic [2:0] funct3;
      logic [6:0] funct7;
      d = '0;
      funct3 = instr[14:12];
      funct7 = instr[31:25];
      d.rs1 = instr[19:15];
      d.rs2 = instr[24:20];
      d.rd = instr[11:7];
      d.csr = instr[31:20];
      d.ctrl.alu_op = ALU_ADD;
      d.ctrl.wb_src = WB_ALU;
      case (opcode_t'(instr[6:0]))
         OP_REG: begin
            d.ctrl.reg_write = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'b000}: d.ctrl.alu_op = ALU_ADD;
               {7'h20, 3'b000}: d.ctrl.alu_op = ALU_SUB;
               {7'h00, 3'b111}: d.ctrl.alu_op = ALU_AND;
               {7'h00, 3'b110}: d.ctrl.alu_op = ALU_OR;
               {7'h00, 3'b100}: d.ctrl.alu_op = ALU_XOR;
               {7'h00, 3'b010}: d.ctrl.alu_op = ALU_SLT;
               default: begin
                  d.ctrl.reg_write = 1'b0;
                  d.ctrl.illegal = 1'b1;
               end
            endcase
         end
         OP_IMM: begin
            d.imm = {{20{instr[31]}}, instr[31:20]};
            d.ctrl.alu_imm = 1'b1;
            d.ctrl.reg_write = (funct3 == 3'b000);
            d.ctrl.illegal = (funct3 != 3'b000);
         end
         OP_LUI: begin
            d.imm = {instr[31:12], 12'b0};
            d.ctrl.reg_write = 1'b1;
            d.ctrl.wb_src = WB_IMM;
         end
         OP_LOAD: begin
            d.imm = {{20{instr[31]}}, instr[31:20]};
            d.ctrl.alu_imm = 1'b1;
            d.ctrl.wb_src = WB_MEM;
            d.ctrl.mem_read = (funct3 == 3'b010);
            d.ctrl.reg_write = (funct3 == 3'b010);
            d.ctrl.illegal = (funct3 != 3'b010);
         end
         OP_STORE: begin
            d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            d.ctrl.alu_imm = 1'b1;
            d.ctrl.mem_write = (funct3 == 3'b010);
            d.ctrl.illegal = (funct3 != 3'b010);
         end
         OP_BRANCH: begin
            d.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            d.ctrl.alu_op = funct3[0] ? ALU_NE : ALU_EQ;
            d.ctrl.is_branch = (funct3[2:1] == 2'b00);
            d.ctrl.illegal = (funct3[2:1] != 2'b00);
         end
         OP_JAL: begin
            d.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            d.ctrl.is_jal = 1'b1;
            d.ctrl.reg_write = 1'b1;
            d.ctrl.wb_src = WB_PC4;
         end
         OP_SYSTEM: begin
            if (funct3 == 3'b001) begin
               d.ctrl.csr_write = 1'b1;
               d.ctrl.reg_write = 1'b1;
               d.ctrl.wb_src = WB_CSR;
            end else if (instr == INSTR_ECALL) begin
               d.ctrl.is_ecall = 1'b1;
            end else if (instr == INSTR_MRET) begin
               d.ctrl.is_mret = 1'b1;
            end else begin
               d.ctrl.illegal = 1'b1;
            end
         end
         default: d.ctrl.illegal = 1'b1;
      endcase
      return d;
   endfunction

endpackage

//--- logic/rv_soc.sv
module rv_soc #(
   parameter int RAM_DEPTH = 64
) (
   input  logic           clk,
   input  logic           rst,
   input  rv_pkg::instr_t instr_i,
   output rv_pkg::word_t  pc_o,
   output logic           st_valid_o,
   output rv_pkg::word_t  st_addr_o,
   output rv_pkg::word_t  st_data_o
);
   import rv_pkg::*;

   word_t mem_addr;
   word_t mem_wd;
   word_t mem_rd;
   logic  mem_we;

   rv_core u_core (
      .clk        (clk),
      .rst        (rst),
      .instr_i    (instr_i),
      .pc_o       (pc_o),
      .mem_addr_o (mem_addr),
      .mem_wd_o   (mem_wd),
      .mem_we_o   (mem_we),
      .mem_rd_i   (mem_rd)
   );

   data_ram #(
      .DEPTH (RAM_DEPTH)
   ) u_ram (
      .clk    (clk),
      .we_i   (mem_we),
      .addr_i (mem_addr),
      .wd_i   (mem_wd),
      .rd_o   (mem_rd)
   );

   // Store monitor
   assign st_valid_o = mem_we;
   assign st_addr_o = mem_addr;
   assign st_data_o = mem_wd;

endmodule

//--- logic/trap_detect.sv
module trap_detect (
   input  rv_pkg::ctrl_t ctrl_i,
   input  rv_pkg::word_t addr_i,
   input  logic          timer_pend_i,
   output rv_pkg::trap_t trap_o
);
   import rv_pkg::*;

   logic misalign;

   assign misalign = (addr_i[1:0] != 2'b00);

   // Timer first, then illegal, ecall, misaligned word access
   always_comb begin
      trap_o = '{take: 1'b0, cause: '0};
      if (timer_pend_i) begin
         trap_o = '{take: 1'b1, cause: CAUSE_TIMER};
      end else if (ctrl_i.illegal) begin
         trap_o = '{take: 1'b1, cause: CAUSE_ILLEGAL};
      end else if (ctrl_i.is_ecall) begin
         trap_o = '{take: 1'b1, cause: CAUSE_ECALL};
      end else if (ctrl_i.mem_read && misalign) begin
         trap_o = '{take: 1'b1, cause: CAUSE_LD_MISALIGN};
      end else if (ctrl_i.mem_write && misalign) begin
         trap_o = '{take: 1'b1, cause: CAUSE_ST_MISALIGN};
      end
   end

   always_comb begin
      if (trap_o.take) begin
         a_cause_known: assert (trap_o.cause inside {CAUSE_ILLEGAL, CAUSE_LD_MISALIGN,
            CAUSE_ST_MISALIGN, CAUSE_ECALL, CAUSE_TIMER});
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module rv_soc_tb -f rv_soc.f
out=$(./obj_dir/Vrv_soc_tb)
echo "$out"
if echo "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

//--- rv_soc.f
+incdir+tb
logic/rv_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/csr_timer.sv
logic/trap_detect.sv
logic/rv_core.sv
logic/data_ram.sv
logic/rv_soc.sv
tb/rv_soc_tb.sv

//--- tb/rv_asm.svh
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// Base formats, fields taken from the low bits of each argument
function automatic instr_t r_format(int f7, int f3, int rd, int rs1, int rs2);
   return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
endfunction

function automatic instr_t i_format(opcode_t op, int f3, int rd, int rs1, int imm);
   return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic instr_t b_format(int f3, int rs1, int rs2, int imm);
   return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic instr_t add_insn(int rd, int rs1, int rs2);
   return r_format('h00, 0, rd, rs1, rs2);
endfunction

function automatic instr_t sub_insn(int rd, int rs1, int rs2);
   return r_format('h20, 0, rd, rs1, rs2);
endfunction

function automatic instr_t and_insn(int rd, int rs1, int rs2);
   return r_format('h00, 7, rd, rs1, rs2);
endfunction

function automatic instr_t or_insn(int rd, int rs1, int rs2);
   return r_format('h00, 6, rd, rs1, rs2);
endfunction

function automatic instr_t xor_insn(int rd, int rs1, int rs2);
   return r_format('h00, 4, rd, rs1, rs2);
endfunction

function automatic instr_t slt_insn(int rd, int rs1, int rs2);
   return r_format('h00, 2, rd, rs1, rs2);
endfunction

function automatic instr_t addi_insn(int rd, int rs1, int imm);
   return i_format(OP_IMM, 0, rd, rs1, imm);
endfunction

function automatic instr_t lui_insn(int rd, int imm20);
   return {imm20[19:0], rd[4:0], OP_LUI};
endfunction

function automatic instr_t lw_insn(int rd, int rs1, int imm);
   return i_format(OP_LOAD, 2, rd, rs1, imm);
endfunction

function automatic instr_t sw_insn(int rs2, int rs1, int imm);
   return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic instr_t beq_insn(int rs1, int rs2, int imm);
   return b_format(0, rs1, rs2, imm);
endfunction

function automatic instr_t bne_insn(int rs1, int rs2, int imm);
   return b_format(1, rs1, rs2, imm);
endfunction

function automatic instr_t jal_insn(int rd, int imm);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
endfunction

function automatic instr_t csrrw_insn(int rd, int csr, int rs1);
   return i_format(OP_SYSTEM, 1, rd, rs1, csr);
endfunction

function automatic instr_t ecall_insn();
   return i_format(OP_SYSTEM, 0, 0, 0, 0);
endfunction

function automatic instr_t mret_insn();
   return i_format(OP_SYSTEM, 0, 0, 0, 'h302);
endfunction

`endif

//--- tb/rv_soc_tb.sv
module rv_soc_tb;
   import rv_pkg::*;

   `include "rv_asm.svh"

   localparam int ROM_WORDS = 128;
   localparam int HANDLER_IDX = 64;

   typedef struct packed {
      word_t addr;
      word_t data;
   } store_t;

   logic        clk;
   logic        rst;
   instr_t      instr;
   word_t       pc;
   logic        st_valid;
   word_t       st_addr;
   word_t       st_data;

   instr_t      rom [ROM_WORDS];
   store_t      exp_st [$];
   word_t       exp_pc [$];
   int unsigned st_idx = 0;
   int          wr_ptr;
   int          n_instr;
   word_t       halt_pc;
   word_t       rnd [4];
   int          errors = 0;
   int          cycles = 0;
   int          cycle_limit;

   rv_soc #(
      .RAM_DEPTH (64)
   ) dut0 (
      .clk        (clk),
      .rst        (rst),
      .instr_i    (instr),
      .pc_o       (pc),
      .st_valid_o (st_valid),
      .st_addr_o  (st_addr),
      .st_data_o  (st_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ROM word for the PC of the coming edge
   always @(negedge clk) begin
      instr <= rom[pc[8:2]];
   end

   ////////////////////////////////////////
   // Program
   ////////////////////////////////////////

   task automatic emit(instr_t w);
      rom[wr_ptr] = w;
      wr_ptr++;
      n_instr++;
   endtask

   task automatic build_program();
      foreach (rom[i])
         rom[i] = '0;
      foreach (rnd[i])
         rnd[i] = $urandom();
      wr_ptr = 0;
      n_instr = 0;
      emit(addi_insn(1, 0, 'h100));
      emit(csrrw_insn(0, int'(CSR_MTVEC), 1));
      // Random operands
      emit(lui_insn(2, rnd[0]));
      emit(addi_insn(2, 2, rnd[1]));
      emit(addi_insn(3, 0, rnd[2]));
      emit(lui_insn(4, rnd[3]));
      emit(add_insn(5, 2, 3));
      emit(sw_insn(5, 0, 0));
      emit(sub_insn(5, 2, 4));
      emit(sw_insn(5, 0, 4));
      emit(and_insn(5, 2, 4));
      emit(sw_insn(5, 0, 8));
      emit(or_insn(5, 3, 4));
      emit(sw_insn(5, 0, 12));
      emit(xor_insn(5, 2, 3));
      emit(sw_insn(5, 0, 16));
      emit(slt_insn(5, 2, 4));
      emit(sw_insn(5, 0, 20));
      emit(slt_insn(5, 3, 2));
      emit(sw_insn(5, 0, 24));
      // Store, load back, store again
      emit(sw_insn(2, 0, 28));
      emit(lw_insn(6, 0, 28));
      emit(sw_insn(6, 0, 32));
      // Branches and JAL with marker stores
      emit(addi_insn(7, 0, 1));
      emit(beq_insn(0, 0, 8));
      emit(sw_insn(2, 0, 36));
      emit(sw_insn(3, 0, 40));
      emit(beq_insn(7, 0, 8));
      emit(sw_insn(7, 0, 44));
      emit(bne_insn(7, 0, 8));
      emit(sw_insn(2, 0, 48));
      emit(bne_insn(0, 0, 8));
      emit(sw_insn(3, 0, 52));
      emit(jal_insn(8, 8));
      emit(sw_insn(2, 0, 56));
      emit(sw_insn(8, 0, 60));
      // Synchronous traps
      emit(ecall_insn());
      emit(sw_insn(7, 0, 64));
      emit(32'h0000_0000);
      emit(sw_insn(7, 0, 68));
      emit(sw_insn(1, 0, 2));
      emit(sw_insn(7, 0, 72));
      // Timer interrupt, then two mtime reads
      emit(lui_insn(5, 1));
      emit(sw_insn(0, 5, 4));
      emit(addi_insn(6, 0, 'h80));
      emit(csrrw_insn(0, int'(CSR_MIE), 6));
      emit(addi_insn(9, 0, 5));
      emit(sw_insn(9, 0, 76));
      emit(lw_insn(9, 5, 0));
      emit(addi_insn(0, 0, 0));
      emit(lw_insn(10, 5, 0));
      emit(sub_insn(11, 10, 9));
      emit(sw_insn(11, 0, 88));
      halt_pc = word_t'(wr_ptr * 4);
      emit(jal_insn(0, 0));
      // Handler at 0x100
      wr_ptr = HANDLER_IDX;
      emit(csrrw_insn(20, int'(CSR_MCAUSE), 0));
      emit(csrrw_insn(21, int'(CSR_MEPC), 0));
      emit(sw_insn(20, 0, 'h80));
      emit(sw_insn(21, 0, 'h84));
      emit(addi_insn(21, 21, 4));
      emit(csrrw_insn(0, int'(CSR_MEPC), 21));
      emit(addi_insn(22, 0, -1));
      emit(lui_insn(23, 1));
      emit(sw_insn(22, 23, 4));
      emit(mret_insn());
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   task automatic run_model();
      word_t  x [32];
      word_t  dmem [word_t];
      word_t  pc_m;
      word_t  nxt;
      word_t  a;
      word_t  b;
      word_t  wval;
      word_t  addr;
      word_t  cause;
      word_t  mtvec;
      word_t  mepc;
      word_t  mcause;
      word_t  mie;
      word_t  mtime;
      word_t  mtimecmp;
      word_t  imm_i;
      word_t  imm_s;
      word_t  imm_b;
      word_t  imm_j;
      instr_t ins;
      logic   mpie;
      logic   trap;
      logic   wr;
      logic   mtime_wr;
      int     steps;
      foreach (x[i])
         x[i] = '0;
      pc_m = '0;
      mtvec = '0;
      mepc = '0;
      mcause = '0;
      mie = '0;
      mpie = 1'b0;
      mtime = '0;
      mtimecmp = '1;
      steps = 0;
      while ((pc_m != halt_pc) && (steps < 1000)) begin
         exp_pc.push_back(pc_m);
         ins = rom[pc_m[8:2]];
         a = x[ins[19:15]];
         b = x[ins[24:20]];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         nxt = pc_m + 32'd4;
         wr = 1'b0;
         wval = '0;
         trap = 1'b1;
         cause = CAUSE_ILLEGAL;
         mtime_wr = 1'b0;
         if (mie[7] && (mtime >= mtimecmp)) begin
            cause = CAUSE_TIMER;
         end else begin
            trap = 1'b0;
            case (ins[6:0])
               OP_REG: begin
                  wr = 1'b1;
                  case (ins[14:12])
                     3'b000: wval = ins[30] ? a - b : a + b;
                     3'b111: wval = a & b;
                     3'b110: wval = a | b;
                     3'b100: wval = a ^ b;
                     default: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  endcase
               end
               OP_IMM: begin
                  wr = 1'b1;
                  wval = a + imm_i;
               end
               OP_LUI: begin
                  wr = 1'b1;
                  wval = {ins[31:12], 12'b0};
               end
               OP_LOAD: begin
                  addr = a + imm_i;
                  if (addr[1:0] != 2'b00) begin
                     trap = 1'b1;
                     cause = CAUSE_LD_MISALIGN;
                  end else begin
                     wr = 1'b1;
                     if (addr == MTIME_ADDR)
                        wval = mtime;
                     else if (addr == MTIMECMP_ADDR)
                        wval = mtimecmp;
                     else
                        wval = dmem[addr];
                  end
               end
               OP_STORE: begin
                  addr = a + imm_s;
                  if (addr[1:0] != 2'b00) begin
                     trap = 1'b1;
                     cause = CAUSE_ST_MISALIGN;
                  end else begin
                     exp_st.push_back('{addr: addr, data: b});
                     if (addr == MTIME_ADDR)
                        mtime_wr = 1'b1;
                     else if (addr == MTIMECMP_ADDR)
                        mtimecmp = b;
                     else
                        dmem[addr] = b;
                  end
               end
               OP_BRANCH: begin
                  if ((a == b) != ins[12])
                     nxt = pc_m + imm_b;
               end
               OP_JAL: begin
                  wr = 1'b1;
                  wval = pc_m + 32'd4;
                  nxt = pc_m + imm_j;
               end
               OP_SYSTEM: begin
                  if (ins[14:12] == 3'b001) begin
                     wr = 1'b1;
                     case (ins[31:20])
                        CSR_MTVEC: begin
                           wval = mtvec;
                           mtvec = a;
                        end
                        CSR_MEPC: begin
                           wval = mepc;
                           mepc = a;
                        end
                        CSR_MCAUSE: begin
                           wval = mcause;
                           mcause = a;
                        end
                        CSR_MIE: begin
                           wval = mie;
                           mie = a;
                        end
                        default: wval = '0;
                     endcase
                  end else if (ins == INSTR_ECALL) begin
                     trap = 1'b1;
                     cause = CAUSE_ECALL;
                  end else if (ins == INSTR_MRET) begin
                     nxt = mepc;
                     mie[7] = mpie;
                  end else begin
                     trap = 1'b1;
                  end
               end
               default: trap = 1'b1;
            endcase
         end
         if (trap) begin
            mepc = pc_m;
            mcause = cause;
            mpie = mie[7];
            mie[7] = 1'b0;
            nxt = mtvec;
         end else if (wr && (ins[11:7] != 5'd0)) begin
            x[ins[11:7]] = wval;
         end
         mtime = mtime_wr ? b : mtime + 32'd1;
         pc_m = nxt;
         steps++;
      end
   endtask

   ////////////////////////////////////////
   // Store scoreboard
   ////////////////////////////////////////

   always @(posedge clk) begin
      if (!rst && st_valid) begin
         st_idx <= st_idx + 1;
      end
   end

   a_st_expected: assert property (@(posedge clk) disable iff (rst)
      st_valid |-> (st_idx < exp_st.size())) else begin
      errors++;
      $display("Store to %h that the model does not expect", $sampled(st_addr));
   end

   a_st_addr: assert property (@(posedge clk) disable iff (rst)
      (st_valid && (st_idx < exp_st.size())) |-> (st_addr == exp_st[st_idx].addr)) else begin
      errors++;
      $display("ERR st_addr_o got %h expected %h", $sampled(st_addr),
         exp_st[$sampled(st_idx)].addr);
   end

   a_st_data: assert property (@(posedge clk) disable iff (rst)
      (st_valid && (st_idx < exp_st.size())) |-> (st_data == exp_st[st_idx].data)) else begin
      errors++;
      $display("ERR st_data_o got %h expected %h", $sampled(st_data),
         exp_st[$sampled(st_idx)].data);
   end

   // One model PC per cycle after reset
   a_pc_trace: assert property (@(posedge clk) disable iff (rst)
      (cycles < exp_pc.size()) |-> (pc == exp_pc[cycles])) else begin
      errors++;
      $display("ERR pc_o got %h expected %h", $sampled(pc), exp_pc[$sampled(cycles)]);
   end

   // Run limit in cycles after reset
   always @(posedge clk) begin
      if (rst) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
         if (cycles >= cycle_limit) begin
            $display("Timeout, PC did not reach %h within %0d cycles", halt_pc, cycle_limit);
            $display("Finished with errors");
            $finish;
         end
      end
   end

   initial begin
      void'($urandom(32'h6f27));
      rst = 1'b1;
      instr = '0;
      build_program();
      run_model();
      cycle_limit = n_instr * 4;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      while (pc !== halt_pc)
         @(negedge clk);
      a_all_stores: assert (st_idx == exp_st.size()) else begin
         errors++;
         $display("Store count wrong, %0d seen and %0d expected", st_idx, exp_st.size());
      end
      $display("Stores checked %0d, errors %0d", st_idx, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
